//--- tx_cfg_pkg.sv
/*
 * Settings bus and error policy definitions for the transmit timing stage.
 * Register offsets are added to a block base address by each user.
 */
package tx_cfg_pkg;

   typedef logic [7:0] set_addr_t;

   // One write per strobe, decoded by each register against its own address
   typedef struct packed {
      logic       stb;
      set_addr_t  addr;
      logic [31:0] data;
   } set_bus_t;

   localparam int OFS_TIME_HI = 0;
   localparam int OFS_TIME_LO = 1;
   localparam int OFS_POLICY  = 3;

   // Bit 0 is wait, bit 1 next packet, bit 2 next burst
   typedef struct packed {
      logic next_burst;
      logic next_packet;
      logic wait_en;
   } policy_t;

endpackage

//--- tx_pkt_pkg.sv
/*
 * Packet word, time and status code definitions for the transmit stage.
 * Shared by the sample queue, the time logic and the burst control FSM.
 */
package tx_pkt_pkg;

   typedef logic [63:0] vita_time_t;
   typedef logic [15:0] seqnum_t;
   typedef logic [31:0] sample_t;
   typedef logic [15:0] code_kind_t;

   // One deframed sample with its packet header fields alongside
   typedef struct packed {
      sample_t    sample;
      logic       seqnum_err;
      logic       send_at;
      logic       sob;
      logic       eob;
      logic       eop;
      seqnum_t    seqnum;
      vita_time_t send_time;
   } pkt_word_t;

   typedef struct packed {
      seqnum_t    seqnum;
      code_kind_t kind;
   } status_code_t;

   localparam code_kind_t EOB_ACK            = 16'd1;
   localparam code_kind_t UNDERRUN           = 16'd2;
   localparam code_kind_t SEQ_ERROR          = 16'd4;
   localparam code_kind_t TIME_ERROR         = 16'd8;
   localparam code_kind_t UNDERRUN_MIDPKT    = 16'd16;
   localparam code_kind_t SEQ_ERROR_MIDBURST = 16'd32;

   typedef enum logic [2:0] {IDLE, RUN, CONT_BURST, ERROR, ERROR_DONE, ERROR_WAIT} ctrl_state_t;

endpackage

//--- setting_reg.sv
/*
 * Single 32-bit register on the settings bus at address ADDR.
 * changed_o pulses for one cycle after each write.
 */
`timescale 1ns/100ps

module setting_reg #(
   parameter int          ADDR      = 0,
   parameter logic [31:0] RESET_VAL = '0
) (
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  tx_cfg_pkg::set_bus_t set_i,
   output logic [31:0]          value_o,
   output logic                 changed_o
);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == tx_cfg_pkg::set_addr_t'(ADDR));

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         value_o   <= RESET_VAL;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit;
         if (hit)
            value_o <= set_i.data;
      end
   end

endmodule

//--- time_compare.sv
/*
 * Compares the running vita time against a packet trigger time.
 * All results come from a single 65-bit subtraction.
 */
`timescale 1ns/100ps

module time_compare #(
   parameter tx_pkt_pkg::vita_time_t TOO_EARLY_TICKS = 64'd100_000_000
) (
   input  tx_pkt_pkg::vita_time_t now_time_i,
   input  tx_pkt_pkg::vita_time_t trigger_time_i,
   output logic                   now_o,
   output logic                   early_o,
   output logic                   late_o,
   output logic                   too_early_o
);

   // Trigger minus now, the top bit is the borrow
   logic [64:0] diff;

   assign diff = {1'b0, trigger_time_i} - {1'b0, now_time_i};

   assign now_o       = (diff == '0);
   assign late_o      = diff[64];
   assign early_o     = ~diff[64] & ~now_o;
   // Trigger further ahead than the allowed window
   assign too_early_o = early_o & (diff[63:0] > TOO_EARLY_TICKS);

endmodule

//--- vita_time_counter.sv
/*
 * Free-running vita time in clock ticks.
 * Write the high word first, the write to the low word loads both.
 */
`timescale 1ns/100ps

module vita_time_counter #(
   parameter int CFG_BASE = 0
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  tx_cfg_pkg::set_bus_t   set_i,
   output tx_pkt_pkg::vita_time_t vita_time_o
);

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        lo_changed;

   setting_reg #(.ADDR(CFG_BASE + tx_cfg_pkg::OFS_TIME_HI), .RESET_VAL('0)) u_sr_hi (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .set_i     (set_i),
      .value_o   (time_hi),
      .changed_o ()
   );

   setting_reg #(.ADDR(CFG_BASE + tx_cfg_pkg::OFS_TIME_LO), .RESET_VAL('0)) u_sr_lo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .set_i     (set_i),
      .value_o   (time_lo),
      .changed_o (lo_changed)
   );

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         vita_time_o <= '0;
      else if (lo_changed)
         vita_time_o <= {time_hi, time_lo};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

endmodule

//--- tx_sample_fifo.sv
/*
 * Packet word queue between the deframer and the burst control.
 * Both sides move a word when source-ready and destination-ready are high.
 */
`timescale 1ns/100ps

module tx_sample_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  clear_i,
   input  tx_pkt_pkg::pkt_word_t word_i,
   input  logic                  src_rdy_i,
   output logic                  dst_rdy_o,
   output tx_pkt_pkg::pkt_word_t word_o,
   output logic                  src_rdy_o,
   input  logic                  dst_rdy_i
);

   localparam int AW = $clog2(FIFO_DEPTH);

   tx_pkt_pkg::pkt_word_t mem [FIFO_DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [AW:0]           count;
   logic                  push;
   logic                  pop;

   assign dst_rdy_o = (count != (AW+1)'(FIFO_DEPTH));
   assign src_rdy_o = (count != '0);
   assign word_o    = mem[rd_ptr];

   assign push = src_rdy_i & dst_rdy_o;
   assign pop  = src_rdy_o & dst_rdy_i;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= word_i;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the fill unchanged
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

//--- vita_tx_control.sv
/*
 * Burst and packet control for the transmit path. Releases queued samples
 * to the DSP strobe at once or at the packet send time, and reports
 * burst acks and underrun, late and sequence errors as status codes.
 */
`timescale 1ns/100ps

module vita_tx_control #(
   parameter int                     CFG_BASE        = 0,
   parameter int                     IDLE_TIMEOUT    = 1000000,
   parameter tx_pkt_pkg::vita_time_t TOO_EARLY_TICKS = 64'd100_000_000
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     clear_i,
   input  tx_cfg_pkg::set_bus_t     set_i,
   input  tx_pkt_pkg::vita_time_t   vita_time_i,
   input  tx_pkt_pkg::pkt_word_t    word_i,
   input  logic                     src_rdy_i,
   input  logic                     strobe_i,
   output logic                     dst_rdy_o,
   output tx_pkt_pkg::sample_t      sample_o,
   output logic                     run_o,
   output logic                     error_o,
   output logic                     ack_o,
   output tx_pkt_pkg::status_code_t error_code_o,
   output logic                     packet_consumed_o
);

   localparam int CW = $clog2(IDLE_TIMEOUT + 1);

   tx_pkt_pkg::ctrl_state_t state;
   tx_cfg_pkg::policy_t     policy;
   logic [31:0]             policy_reg;
   logic                    now, late, too_early;
   logic                    late_del, late_qual;
   logic [CW-1:0]           countdown;

   function automatic tx_pkt_pkg::status_code_t make_code(tx_pkt_pkg::code_kind_t kind);
      tx_pkt_pkg::status_code_t code;
      code.seqnum = word_i.seqnum;
      code.kind   = kind;
      return code;
   endfunction

   time_compare #(.TOO_EARLY_TICKS(TOO_EARLY_TICKS)) u_cmp (
      .now_time_i     (vita_time_i),
      .trigger_time_i (word_i.send_time),
      .now_o          (now),
      .early_o        (),
      .late_o         (late),
      .too_early_o    (too_early)
   );

   setting_reg #(.ADDR(CFG_BASE + tx_cfg_pkg::OFS_POLICY), .RESET_VAL('0)) u_sr_policy (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .set_i     (set_i),
      .value_o   (policy_reg),
      .changed_o ()
   );

   assign policy = tx_cfg_pkg::policy_t'(policy_reg[2:0]);

   // Pop on strobe while running, drain every cycle in ERROR
   assign dst_rdy_o = (state == tx_pkt_pkg::ERROR) | (strobe_i & (state == tx_pkt_pkg::RUN));

   // Late only counts after two cycles with a word waiting and unconsumed
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         late_del  <= 1'b0;
         late_qual <= 1'b0;
      end
      else if (clear_i)
      begin
         late_del  <= 1'b0;
         late_qual <= 1'b0;
      end
      else
      begin
         late_del  <= late;
         late_qual <= src_rdy_i & ~dst_rdy_o;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state        <= tx_pkt_pkg::IDLE;
         error_o      <= 1'b0;
         ack_o        <= 1'b0;
         error_code_o <= '0;
      end
      else if (clear_i)
      begin
         state        <= tx_pkt_pkg::IDLE;
         error_o      <= 1'b0;
         ack_o        <= 1'b0;
         error_code_o <= '0;
      end
      else
      begin
         error_o <= 1'b0;
         ack_o   <= 1'b0;
         case (state)
            tx_pkt_pkg::IDLE:
            begin
               if (src_rdy_i)
               begin
                  if (word_i.seqnum_err)
                  begin
                     state        <= tx_pkt_pkg::ERROR;
                     error_code_o <= make_code(tx_pkt_pkg::SEQ_ERROR);
                     error_o      <= 1'b1;
                  end
                  else if (!word_i.send_at || now)
                     state <= tx_pkt_pkg::RUN;
                  else if ((late_qual && late_del) || too_early)
                  begin
                     state        <= tx_pkt_pkg::ERROR;
                     error_code_o <= make_code(tx_pkt_pkg::TIME_ERROR);
                     error_o      <= 1'b1;
                  end
               end
            end
            tx_pkt_pkg::RUN:
            begin
               if (strobe_i)
               begin
                  if (!src_rdy_i)
                  begin
                     state        <= tx_pkt_pkg::ERROR;
                     error_code_o <= make_code(tx_pkt_pkg::UNDERRUN_MIDPKT);
                     error_o      <= 1'b1;
                  end
                  else if (word_i.eop && word_i.eob)
                  begin
                     // Burst done, acknowledged through the ERROR_DONE step
                     state        <= tx_pkt_pkg::ERROR_DONE;
                     error_code_o <= make_code(tx_pkt_pkg::EOB_ACK);
                     ack_o        <= 1'b1;
                  end
                  else if (word_i.eop)
                     state <= tx_pkt_pkg::CONT_BURST;
               end
            end
            tx_pkt_pkg::CONT_BURST:
            begin
               if (strobe_i)
               begin
                  if (policy.next_packet)
                     state <= tx_pkt_pkg::ERROR_DONE;
                  else if (policy.wait_en)
                     state <= tx_pkt_pkg::ERROR_WAIT;
                  else
                     state <= tx_pkt_pkg::ERROR;
                  error_code_o <= make_code(tx_pkt_pkg::UNDERRUN);
                  error_o      <= 1'b1;
               end
               else if (src_rdy_i)
               begin
                  if (word_i.seqnum_err)
                  begin
                     state        <= tx_pkt_pkg::ERROR;
                     error_code_o <= make_code(tx_pkt_pkg::SEQ_ERROR_MIDBURST);
                     error_o      <= 1'b1;
                  end
                  else
                     state <= tx_pkt_pkg::RUN;
               end
            end
            tx_pkt_pkg::ERROR:
            begin
               if (src_rdy_i && word_i.eop)
               begin
                  if (policy.next_packet || (policy.next_burst && word_i.eob))
                     state <= tx_pkt_pkg::IDLE;
                  else if (policy.wait_en)
                     state <= tx_pkt_pkg::ERROR_WAIT;
               end
            end
            tx_pkt_pkg::ERROR_DONE:
               state <= tx_pkt_pkg::IDLE;
            // ERROR_WAIT holds until clear_i
            default:
               state <= state;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         sample_o <= '0;
      else if (clear_i || !run_o)
         sample_o <= '0;
      else if (strobe_i && state == tx_pkt_pkg::RUN && src_rdy_i)
         sample_o <= word_i.sample;
   end

   // Run holds for IDLE_TIMEOUT cycles outside RUN, or drops at end of burst
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         run_o     <= 1'b0;
         countdown <= '0;
      end
      else if (clear_i)
      begin
         run_o     <= 1'b0;
         countdown <= '0;
      end
      else if (state == tx_pkt_pkg::RUN)
      begin
         if (word_i.eob && word_i.eop && strobe_i && src_rdy_i)
            run_o <= 1'b0;
         else
         begin
            run_o     <= 1'b1;
            countdown <= CW'(IDLE_TIMEOUT);
         end
      end
      else if (countdown == '0)
         run_o <= 1'b0;
      else
         countdown <= countdown - 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         packet_consumed_o <= 1'b0;
      else if (clear_i)
         packet_consumed_o <= 1'b0;
      else
         packet_consumed_o <= word_i.eop & src_rdy_i & dst_rdy_o;
   end

endmodule

//--- vita_tx_core.sv
/*
 * Transmit timing stage top. Deframed packet words pass a sample queue
 * and are released to the DSP strobe by the burst control.
 */
`timescale 1ns/100ps

module vita_tx_core #(
   parameter int                     CFG_BASE        = 0,
   parameter int                     FIFO_DEPTH      = 8,
   parameter int                     IDLE_TIMEOUT    = 1000000,
   parameter tx_pkt_pkg::vita_time_t TOO_EARLY_TICKS = 64'd100_000_000
) (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     clear_i,
   input  tx_cfg_pkg::set_bus_t     set_i,
   input  tx_pkt_pkg::pkt_word_t    pkt_i,
   input  logic                     pkt_src_rdy_i,
   output logic                     pkt_dst_rdy_o,
   input  logic                     strobe_i,
   output tx_pkt_pkg::sample_t      sample_o,
   output logic                     run_o,
   output logic                     error_o,
   output logic                     ack_o,
   output tx_pkt_pkg::status_code_t error_code_o,
   output logic                     packet_consumed_o,
   output tx_pkt_pkg::vita_time_t   vita_time_o
);

   tx_pkt_pkg::pkt_word_t  q_word;
   logic                   q_src_rdy;
   logic                   q_dst_rdy;
   tx_pkt_pkg::vita_time_t vita_time;

   assign vita_time_o = vita_time;

   tx_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (clear_i),
      .word_i    (pkt_i),
      .src_rdy_i (pkt_src_rdy_i),
      .dst_rdy_o (pkt_dst_rdy_o),
      .word_o    (q_word),
      .src_rdy_o (q_src_rdy),
      .dst_rdy_i (q_dst_rdy)
   );

   // Time keeps running through clear_i
   vita_time_counter #(.CFG_BASE(CFG_BASE)) u_time (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .set_i       (set_i),
      .vita_time_o (vita_time)
   );

   vita_tx_control #(
      .CFG_BASE        (CFG_BASE),
      .IDLE_TIMEOUT    (IDLE_TIMEOUT),
      .TOO_EARLY_TICKS (TOO_EARLY_TICKS)
   ) u_ctrl (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .clear_i           (clear_i),
      .set_i             (set_i),
      .vita_time_i       (vita_time),
      .word_i            (q_word),
      .src_rdy_i         (q_src_rdy),
      .strobe_i          (strobe_i),
      .dst_rdy_o         (q_dst_rdy),
      .sample_o          (sample_o),
      .run_o             (run_o),
      .error_o           (error_o),
      .ack_o             (ack_o),
      .error_code_o      (error_code_o),
      .packet_consumed_o (packet_consumed_o)
   );

endmodule

//--- tb_vita_tx_core.sv
/*
 * Directed testbench for the transmit timing stage. Each test pushes packets,
 * strobes the DSP side and checks samples, status codes and run timing.
 */
`timescale 1ns/100ps

module tb_vita_tx_core;

   localparam int          CLK_PERIOD = 100;
   localparam int          CFG_BASE   = 0;
   localparam int          FIFO_DEPTH = 8;
   localparam int          IDLE_TO    = 40;
   localparam logic [31:0] SEED       = 32'h0d6c26d6;
   // Rough cycle budget per test, idle timeout waits included
   localparam int TEST_CYCLES = 20 + 40 + 120 + 60 + (80 + 2 * IDLE_TO)
                                + (100 + 4 * IDLE_TO) + (120 + 3 * IDLE_TO);
   localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 200;

   logic                     clk;
   logic                     rst_n_i;
   logic                     clear_i;
   tx_cfg_pkg::set_bus_t     set_i;
   tx_pkt_pkg::pkt_word_t    pkt_i;
   logic                     pkt_src_rdy_i;
   logic                     pkt_dst_rdy_o;
   logic                     strobe_i;
   tx_pkt_pkg::sample_t      sample_o;
   logic                     run_o;
   logic                     error_o;
   logic                     ack_o;
   tx_pkt_pkg::status_code_t error_code_o;
   logic                     packet_consumed_o;
   tx_pkt_pkg::vita_time_t   vita_time_o;

   int                  pass_cnt;
   int                  fail_cnt;
   int                  test_errs;
   int                  ack_cnt;
   int                  consumed_cnt;
   string               cur_test;
   tx_pkt_pkg::sample_t exp_q [$];

   vita_tx_core #(
      .CFG_BASE        (CFG_BASE),
      .FIFO_DEPTH      (FIFO_DEPTH),
      .IDLE_TIMEOUT    (IDLE_TO),
      .TOO_EARLY_TICKS (64'd100000)
   ) u_vita_tx_core (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .clear_i           (clear_i),
      .set_i             (set_i),
      .pkt_i             (pkt_i),
      .pkt_src_rdy_i     (pkt_src_rdy_i),
      .pkt_dst_rdy_o     (pkt_dst_rdy_o),
      .strobe_i          (strobe_i),
      .sample_o          (sample_o),
      .run_o             (run_o),
      .error_o           (error_o),
      .ack_o             (ack_o),
      .error_code_o      (error_code_o),
      .packet_consumed_o (packet_consumed_o),
      .vita_time_o       (vita_time_o)
   );

   always
   begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
   end

   // Pulse counters, sampled where the registered outputs are stable
   always @(negedge clk)
   begin
      if (rst_n_i)
      begin
         if (ack_o)
            ack_cnt++;
         if (packet_consumed_o)
            consumed_cnt++;
      end
   end

   task automatic tally(input logic ok, input string what, input string exp_s,
                        input string act_s);
      if (ok)
         pass_cnt++;
      else
      begin
         fail_cnt++;
         test_errs++;
         $display("MISMATCH %s %s expected %s actual %s", cur_test, what, exp_s, act_s);
      end
   endtask

   task automatic fail_plain(input string msg);
      fail_cnt++;
      test_errs++;
      $display("ERROR in %s: %s", cur_test, msg);
   endtask

   task automatic check_sample(input string what, input tx_pkt_pkg::sample_t exp,
                               input tx_pkt_pkg::sample_t act);
      tally(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_code(input string what, input tx_pkt_pkg::status_code_t exp,
                             input tx_pkt_pkg::status_code_t act);
      tally(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_kind(input string what, input tx_pkt_pkg::code_kind_t exp,
                             input tx_pkt_pkg::code_kind_t act);
      tally(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_time(input string what, input tx_pkt_pkg::vita_time_t exp,
                             input tx_pkt_pkg::vita_time_t act);
      tally(exp === act, what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      tally(exp === act, what, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   task automatic check_count(input string what, input int exp, input int act);
      tally(exp == act, what, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   function automatic tx_pkt_pkg::status_code_t code_word(input tx_pkt_pkg::seqnum_t seq,
                                                          input tx_pkt_pkg::code_kind_t kind);
      tx_pkt_pkg::status_code_t c;
      c.seqnum = seq;
      c.kind   = kind;
      return c;
   endfunction

   task automatic begin_test(input string name);
      cur_test  = name;
      test_errs = 0;
      exp_q.delete();
   endtask

   task automatic end_test();
      $display("Test %s finished with %0d errors", cur_test, test_errs);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // All drive tasks start and end on a falling edge
   task automatic write_reg(input int ofs, input logic [31:0] data);
      set_i.stb  = 1'b1;
      set_i.addr = tx_cfg_pkg::set_addr_t'(CFG_BASE + ofs);
      set_i.data = data;
      @(negedge clk);
      set_i.stb  = 1'b0;
   endtask

   task automatic push_packet(input tx_pkt_pkg::seqnum_t seq, input int n, input logic send_at,
                              input tx_pkt_pkg::vita_time_t send_time, input logic has_eop,
                              input logic eob, input logic seq_err);
      tx_pkt_pkg::pkt_word_t w;
      logic                  taken;
      int                    i;
      for (i = 0; i < n; i++)
      begin
         w            = '0;
         w.sample     = tx_pkt_pkg::sample_t'($urandom);
         w.seqnum_err = seq_err;
         w.send_at    = send_at;
         w.sob        = (i == 0);
         w.eop        = has_eop && (i == n - 1);
         w.eob        = eob && (i == n - 1);
         w.seqnum     = seq;
         w.send_time  = send_time;
         exp_q.push_back(w.sample);
         pkt_i         = w;
         pkt_src_rdy_i = 1'b1;
         taken         = 1'b0;
         while (!taken)
         begin
            taken = pkt_dst_rdy_o;
            @(negedge clk);
         end
      end
      pkt_src_rdy_i = 1'b0;
   endtask

   task automatic strobe_once();
      strobe_i = 1'b1;
      @(negedge clk);
      strobe_i = 1'b0;
   endtask

   // Sample is valid the cycle after its strobe
   task automatic play_samples(input int n);
      repeat (n)
      begin
         strobe_once();
         check_sample("sample_o", exp_q.pop_front(), sample_o);
      end
   endtask

   task automatic wait_run(input logic level, input int limit);
      int n;
      n = 0;
      while (run_o !== level && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (run_o !== level)
         fail_plain($sformatf("run_o did not go to %b within %0d cycles", level, limit));
   endtask

   task automatic wait_error(input int limit);
      int n;
      n = 0;
      while (error_o !== 1'b1 && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (error_o !== 1'b1)
         fail_plain($sformatf("no error_o pulse within %0d cycles", limit));
   endtask

   task automatic settle();
      wait_run(1'b0, 2 * IDLE_TO + 10);
      idle_cycles(3);
   endtask

   task automatic reset_values();
      begin_test("reset_values");
      check_bit("run_o", 1'b0, run_o);
      check_bit("error_o", 1'b0, error_o);
      check_bit("ack_o", 1'b0, ack_o);
      check_bit("packet_consumed_o", 1'b0, packet_consumed_o);
      check_bit("pkt_dst_rdy_o on empty queue", 1'b1, pkt_dst_rdy_o);
      check_sample("sample_o", '0, sample_o);
      check_code("error_code_o", '0, error_code_o);
      end_test();
   endtask

   task automatic immediate_burst();
      int acks;
      int cons;
      begin_test("immediate_burst");
      acks = ack_cnt;
      cons = consumed_cnt;
      push_packet(16'd1, 4, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      wait_run(1'b1, 20);
      play_samples(4);
      check_bit("ack_o", 1'b1, ack_o);
      check_code("ack code", code_word(16'd1, tx_pkt_pkg::EOB_ACK), error_code_o);
      check_bit("run_o after end of burst", 1'b0, run_o);
      idle_cycles(4);
      check_count("ack pulses", 1, ack_cnt - acks);
      check_count("packet_consumed pulses", 1, consumed_cnt - cons);
      end_test();
   endtask

   task automatic timed_start();
      tx_pkt_pkg::vita_time_t t0;
      tx_pkt_pkg::vita_time_t trigger;
      int                     n;
      begin_test("timed_start");
      t0 = {32'h0000_0001, 32'h0000_1000};
      write_reg(tx_cfg_pkg::OFS_TIME_HI, t0[63:32]);
      write_reg(tx_cfg_pkg::OFS_TIME_LO, t0[31:0]);
      @(negedge clk);
      check_time("loaded time", t0, vita_time_o);
      @(negedge clk);
      check_time("time after one tick", t0 + 64'd1, vita_time_o);
      trigger = t0 + 64'd50;
      push_packet(16'd2, 3, 1'b1, trigger, 1'b1, 1'b1, 1'b0);
      n = 0;
      while (vita_time_o < trigger && n < 100)
      begin
         check_bit("run_o before send time", 1'b0, run_o);
         @(negedge clk);
         n++;
      end
      wait_run(1'b1, 10);
      // State enters RUN at the send time, run_o follows one cycle later
      check_time("time at run rise", trigger + 64'd2, vita_time_o);
      play_samples(3);
      check_code("ack code", code_word(16'd2, tx_pkt_pkg::EOB_ACK), error_code_o);
      end_test();
   endtask

   task automatic late_packet();
      int acks;
      int cons;
      begin_test("late_packet");
      write_reg(tx_cfg_pkg::OFS_POLICY, 32'h2);
      cons = consumed_cnt;
      push_packet(16'd3, 2, 1'b1, vita_time_o - 64'd20, 1'b1, 1'b1, 1'b0);
      exp_q.delete();
      wait_error(20);
      check_code("late code", code_word(16'd3, tx_pkt_pkg::TIME_ERROR), error_code_o);
      idle_cycles(6);
      check_count("packet_consumed pulses", 1, consumed_cnt - cons);
      check_sample("sample_o while discarding", '0, sample_o);
      acks = ack_cnt;
      push_packet(16'd4, 2, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      wait_run(1'b1, 20);
      play_samples(2);
      check_code("ack code", code_word(16'd4, tx_pkt_pkg::EOB_ACK), error_code_o);
      idle_cycles(3);
      check_count("ack pulses", 1, ack_cnt - acks);
      end_test();
   endtask

   task automatic sequence_errors();
      int cons;
      begin_test("sequence_errors");
      cons = consumed_cnt;
      push_packet(16'd5, 2, 1'b0, '0, 1'b1, 1'b1, 1'b1);
      exp_q.delete();
      wait_error(20);
      check_code("seq code", code_word(16'd5, tx_pkt_pkg::SEQ_ERROR), error_code_o);
      idle_cycles(5);
      check_count("packet_consumed pulses", 1, consumed_cnt - cons);
      // Second burst, the continuation packet carries the sequence error
      push_packet(16'd6, 2, 1'b0, '0, 1'b1, 1'b0, 1'b0);
      push_packet(16'd7, 2, 1'b0, '0, 1'b1, 1'b1, 1'b1);
      wait_run(1'b1, 20);
      play_samples(2);
      wait_error(20);
      check_code("midburst code", code_word(16'd7, tx_pkt_pkg::SEQ_ERROR_MIDBURST),
                 error_code_o);
      settle();
      end_test();
   endtask

   task automatic underruns();
      int cons;
      begin_test("underruns");
      push_packet(16'd8, 2, 1'b0, '0, 1'b1, 1'b0, 1'b0);
      wait_run(1'b1, 20);
      play_samples(2);
      strobe_once();
      check_bit("error_o on underrun", 1'b1, error_o);
      check_kind("underrun kind", tx_pkt_pkg::UNDERRUN, error_code_o.kind);
      settle();
      push_packet(16'd9, 2, 1'b0, '0, 1'b0, 1'b0, 1'b0);
      wait_run(1'b1, 20);
      play_samples(2);
      strobe_once();
      check_bit("error_o mid packet", 1'b1, error_o);
      check_kind("mid packet kind", tx_pkt_pkg::UNDERRUN_MIDPKT, error_code_o.kind);
      // A lone end of packet word is discarded and ends the error
      cons = consumed_cnt;
      push_packet(16'd10, 1, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      idle_cycles(4);
      check_count("discarded packets", 1, consumed_cnt - cons);
      settle();
      end_test();
   endtask

   task automatic wait_and_clear();
      int acks;
      begin_test("wait_and_clear");
      write_reg(tx_cfg_pkg::OFS_POLICY, 32'h1);
      push_packet(16'd11, 1, 1'b0, '0, 1'b1, 1'b1, 1'b1);
      exp_q.delete();
      wait_error(20);
      check_code("seq code", code_word(16'd11, tx_pkt_pkg::SEQ_ERROR), error_code_o);
      idle_cycles(3);
      acks = ack_cnt;
      // Held packets fill the queue until it pushes back
      push_packet(16'd12, FIFO_DEPTH, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      check_bit("pkt_dst_rdy_o when full", 1'b0, pkt_dst_rdy_o);
      repeat (3)
      begin
         strobe_once();
         check_sample("sample_o while held", '0, sample_o);
      end
      check_bit("run_o while held", 1'b0, run_o);
      idle_cycles(3);
      check_count("ack pulses while held", 0, ack_cnt - acks);
      clear_i = 1'b1;
      @(negedge clk);
      clear_i = 1'b0;
      check_bit("pkt_dst_rdy_o after clear", 1'b1, pkt_dst_rdy_o);
      exp_q.delete();
      push_packet(16'd13, 2, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      wait_run(1'b1, 20);
      play_samples(2);
      check_bit("ack_o after clear", 1'b1, ack_o);
      check_code("ack code", code_word(16'd13, tx_pkt_pkg::EOB_ACK), error_code_o);
      // A packet without end of burst leaves run_o to the idle timeout
      push_packet(16'd14, 1, 1'b0, '0, 1'b1, 1'b0, 1'b0);
      wait_run(1'b1, 20);
      play_samples(1);
      idle_cycles(IDLE_TO - 5);
      check_bit("run_o before timeout", 1'b1, run_o);
      idle_cycles(10);
      check_bit("run_o after timeout", 1'b0, run_o);
      end_test();
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      void'($urandom(SEED));
      clk           = 1'b0;
      rst_n_i       = 1'b0;
      clear_i       = 1'b0;
      set_i         = '0;
      pkt_i         = '0;
      pkt_src_rdy_i = 1'b0;
      strobe_i      = 1'b0;
      pass_cnt      = 0;
      fail_cnt      = 0;
      ack_cnt       = 0;
      consumed_cnt  = 0;
      repeat (10) @(negedge clk);
      rst_n_i = 1'b1;
      @(negedge clk);
      reset_values();
      immediate_burst();
      timed_start();
      late_packet();
      sequence_errors();
      underruns();
      wait_and_clear();
      $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- build.f
tx_cfg_pkg.sv
tx_pkt_pkg.sv
setting_reg.sv
time_compare.sv
vita_time_counter.sv
tx_sample_fifo.sv
vita_tx_control.sv
vita_tx_core.sv
tb_vita_tx_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench and RTL with Verilator, run it and judge the result from the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_vita_tx_core -f build.f
./obj_dir/Vtb_vita_tx_core > sim.log 2>&1
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi
